//--- verilog/cpuPkg.sv
package cpuPkg;

	// datapath widths
	localparam int dataWidth = 16;
	localparam int regSelWidth = 3;

	// opcodes, instruction bits 15:11
	localparam logic [4:0] opHalt = 5'b00000;
	localparam logic [4:0] opNop = 5'b00001;
	localparam logic [4:0] opAddi = 5'b01000;
	localparam logic [4:0] opSubi = 5'b01001;
	localparam logic [4:0] opXori = 5'b01010;
	localparam logic [4:0] opAndni = 5'b01011;
	localparam logic [4:0] opSlbi = 5'b10010;
	localparam logic [4:0] opLbi = 5'b11000;
	localparam logic [4:0] opAlu = 5'b11011;

	// function field of opAlu, bits 1:0
	localparam logic [1:0] fnAdd = 2'b00;
	localparam logic [1:0] fnSub = 2'b01;
	localparam logic [1:0] fnXor = 2'b10;
	localparam logic [1:0] fnAndn = 2'b11;

	// destination register field select
	localparam logic [1:0] destRd = 2'b00;
	localparam logic [1:0] destRt = 2'b01;
	localparam logic [1:0] destRs = 2'b10;

	// immediate extension select
	localparam logic [1:0] immSext5 = 2'b00;
	localparam logic [1:0] immZext5 = 2'b01;
	localparam logic [1:0] immSext8 = 2'b10;
	localparam logic [1:0] immZext8 = 2'b11;

	// sub is add with invA and Cin
	typedef enum logic [1:0] {
		aluAdd,
		aluXor,
		aluAndn,
		aluShiftLoad
	} aluOpT;

	// fetch to decode
	typedef struct packed {
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] pc;
	} fetchPayloadT;

	// decode to execute
	typedef struct packed {
		logic [dataWidth-1:0] opA;
		logic [dataWidth-1:0] opB;
		logic [regSelWidth-1:0] writeReg;
		logic regWrite;
		aluOpT aluOp;
		logic invA;
		logic invB;
		logic Cin;
		logic halt;
		logic illegal;
	} execPayloadT;

endpackage

//--- verilog/fetchUnit.sv
`timescale 1ns/100ps
module fetchUnit #(parameter int imemAddrWidth = 6) (
	// inputs
	clk, rstN, imemWrEn, imemWrAddr, imemWrData, run, halt,
	// outputs
	fetchValid, fetchPayload);

	input logic clk, rstN;
	// memory load port
	input logic imemWrEn;
	input logic [imemAddrWidth-1:0] imemWrAddr;
	input logic [cpuPkg::dataWidth-1:0] imemWrData;
	// fetch advances while high
	input logic run;
	// halt or illegal seen in decode
	input logic halt;

	output logic fetchValid;
	output cpuPkg::fetchPayloadT fetchPayload;

	localparam int pcWidth = cpuPkg::dataWidth;

	logic [cpuPkg::dataWidth-1:0] imem [2**imemAddrWidth];
	logic [imemAddrWidth-1:0] pc;
	// set by halt and held until reset
	logic stopped;

	// one word per write cycle
	always_ff @(posedge clk) begin
		if (imemWrEn) begin
			imem[imemWrAddr] <= imemWrData;
		end
	end

	// the word issued next to a halt is dropped by the stage register flush
	assign fetchValid = run && !stopped;

	// asynchronous read at pc
	always_comb begin
		fetchPayload.instr = imem[pc];
		fetchPayload.pc = pcWidth'(pc);
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pc <= '0;
			stopped <= 1'b0;
		end else begin
			if (halt) begin
				stopped <= 1'b1;
			end
			// advance only when a word is issued
			if (fetchValid) begin
				pc <= pc + 1'b1;
			end
		end
	end

	// a stopped machine stays put until reset
	pcHeldWhenStopped: assert property (@(posedge clk) disable iff (!rstN)
		stopped |=> (stopped && $stable(pc)));

endmodule

//--- verilog/stageReg.sv
`timescale 1ns/100ps
module stageReg #(parameter type payloadT = logic) (
	// inputs
	clk, rstN, flush, inValid, inPayload,
	// outputs
	outValid, outPayload);

	input logic clk, rstN;
	// drops whatever is being captured
	input logic flush;
	input logic inValid;
	input payloadT inPayload;

	output logic outValid;
	output payloadT outPayload;

	// valid is the only control bit here
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			outValid <= 1'b0;
		end else begin
			outValid <= inValid;
		end
	end

	// payload follows input every cycle
	always_ff @(posedge clk) begin
		outPayload <= inPayload;
	end

	// downstream gates everything on valid, so it must be clean
	validKnown: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown(outValid));

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/100ps
module controlUnit (
	// inputs
	opCode, funct,
	// outputs
	illegal, regDest, regWrite, immSel, aluOp, invA, invB, Cin, halt);

	input logic [4:0] opCode;
	input logic [1:0] funct;

	output logic illegal;
	// 00 bits 4:2, 01 bits 7:5, 10 bits 10:8
	output logic [1:0] regDest;
	output logic regWrite;
	output logic [1:0] immSel;
	output cpuPkg::aluOpT aluOp;
	output logic invA, invB, Cin;
	output logic halt;

	always_comb begin
		// defaults, nothing written
		illegal = 1'b0;
		regDest = cpuPkg::destRd;
		regWrite = 1'b0;
		immSel = cpuPkg::immSext5;
		aluOp = cpuPkg::aluAdd;
		invA = 1'b0;
		invB = 1'b0;
		Cin = 1'b0;
		halt = 1'b0;

		case (opCode)
			cpuPkg::opHalt: begin
				halt = 1'b1;
			end
			cpuPkg::opNop: begin
			end
			// I-format, Rd in bits 7:5
			cpuPkg::opAddi: begin
				regDest = cpuPkg::destRt;
				regWrite = 1'b1;
			end
			cpuPkg::opSubi: begin
				// imm minus Rs
				regDest = cpuPkg::destRt;
				regWrite = 1'b1;
				invA = 1'b1;
				Cin = 1'b1;
			end
			cpuPkg::opXori: begin
				regDest = cpuPkg::destRt;
				regWrite = 1'b1;
				immSel = cpuPkg::immZext5;
				aluOp = cpuPkg::aluXor;
			end
			cpuPkg::opAndni: begin
				regDest = cpuPkg::destRt;
				regWrite = 1'b1;
				immSel = cpuPkg::immZext5;
				aluOp = cpuPkg::aluAndn;
				invB = 1'b1;
			end
			// Rs is also the destination
			cpuPkg::opSlbi: begin
				regDest = cpuPkg::destRs;
				regWrite = 1'b1;
				immSel = cpuPkg::immZext8;
				aluOp = cpuPkg::aluShiftLoad;
			end
			// add with A forced to zero in decode
			cpuPkg::opLbi: begin
				regDest = cpuPkg::destRs;
				regWrite = 1'b1;
				immSel = cpuPkg::immSext8;
			end
			// R-format, Rd in bits 4:2
			cpuPkg::opAlu: begin
				regWrite = 1'b1;
				case (funct)
					cpuPkg::fnAdd: aluOp = cpuPkg::aluAdd;
					cpuPkg::fnSub: begin
						// Rt minus Rs
						invA = 1'b1;
						Cin = 1'b1;
					end
					cpuPkg::fnXor: aluOp = cpuPkg::aluXor;
					default: begin
						aluOp = cpuPkg::aluAndn;
						invB = 1'b1;
					end
				endcase
			end
			// unknown opcode stops the machine like halt
			default: begin
				illegal = 1'b1;
				halt = 1'b1;
			end
		endcase
	end

endmodule

//--- verilog/regFile.sv
`timescale 1ns/100ps
module regFile (
	// inputs
	clk, rstN, readReg1Sel, readReg2Sel, writeRegSel, writeData, writeEn,
	// outputs
	readData1, readData2);

	input logic clk, rstN;
	input logic [cpuPkg::regSelWidth-1:0] readReg1Sel, readReg2Sel;
	input logic [cpuPkg::regSelWidth-1:0] writeRegSel;
	input logic [cpuPkg::dataWidth-1:0] writeData;
	input logic writeEn;

	output logic [cpuPkg::dataWidth-1:0] readData1, readData2;

	localparam int numRegs = 2**cpuPkg::regSelWidth;

	logic [cpuPkg::dataWidth-1:0] regs [numRegs];

	// all registers start at zero
	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeRegSel] <= writeData;
		end
	end

	// bypass, a write this cycle is seen by reads this cycle
	always_comb begin
		if (writeEn && (writeRegSel == readReg1Sel)) begin
			readData1 = writeData;
		end else begin
			readData1 = regs[readReg1Sel];
		end
	end

	always_comb begin
		if (writeEn && (writeRegSel == readReg2Sel)) begin
			readData2 = writeData;
		end else begin
			readData2 = regs[readReg2Sel];
		end
	end

endmodule

//--- verilog/decodeInstruction.sv
`timescale 1ns/100ps
module decodeInstruction (
	// inputs
	clk, rstN, inValid, inPayload, wrEn, wrReg, wrData,
	// outputs
	halt, outValid, execPayload);

	input logic clk, rstN;
	input logic inValid;
	input cpuPkg::fetchPayloadT inPayload;
	// write port, driven from execute
	input logic wrEn;
	input logic [cpuPkg::regSelWidth-1:0] wrReg;
	input logic [cpuPkg::dataWidth-1:0] wrData;

	// back to fetch, also flushes the first stage register
	output logic halt;
	output logic outValid;
	output cpuPkg::execPayloadT execPayload;

	logic [cpuPkg::dataWidth-1:0] instr;
	// control outputs
	logic ctlIllegal, ctlRegWrite, ctlHalt;
	logic ctlInvA, ctlInvB, ctlCin;
	logic [1:0] ctlRegDest, ctlImmSel;
	cpuPkg::aluOpT ctlAluOp;
	// register file outputs, Rs and Rt
	logic [cpuPkg::dataWidth-1:0] rsData, rtData;
	logic [cpuPkg::regSelWidth-1:0] writeReg;
	logic [cpuPkg::dataWidth-1:0] immExt;

	assign instr = inPayload.instr;

	controlUnit i_controlUnit (
		.opCode(instr[15:11]), .funct(instr[1:0]),
		.illegal(ctlIllegal), .regDest(ctlRegDest), .regWrite(ctlRegWrite),
		.immSel(ctlImmSel), .aluOp(ctlAluOp), .invA(ctlInvA), .invB(ctlInvB),
		.Cin(ctlCin), .halt(ctlHalt));

	// Rs from 10:8, Rt from 7:5
	regFile i_regFile (
		.clk(clk), .rstN(rstN), .readReg1Sel(instr[10:8]), .readReg2Sel(instr[7:5]),
		.writeRegSel(wrReg), .writeData(wrData), .writeEn(wrEn),
		.readData1(rsData), .readData2(rtData));

	// destination field mux
	always_comb begin
		case (ctlRegDest)
			cpuPkg::destRd: writeReg = instr[4:2];
			cpuPkg::destRt: writeReg = instr[7:5];
			default: writeReg = instr[10:8];
		endcase
	end

	// immediate extension
	always_comb begin
		case (ctlImmSel)
			cpuPkg::immSext5: immExt = {{11{instr[4]}}, instr[4:0]};
			cpuPkg::immZext5: immExt = {11'b0, instr[4:0]};
			cpuPkg::immSext8: immExt = {{8{instr[7]}}, instr[7:0]};
			default: immExt = {8'b0, instr[7:0]};
		endcase
	end

	always_comb begin
		// lbi adds its immediate to zero
		execPayload.opA = (instr[15:11] == cpuPkg::opLbi) ? '0 : rsData;
		// only R-format reads Rt as second operand
		execPayload.opB = (instr[15:11] == cpuPkg::opAlu) ? rtData : immExt;
		execPayload.writeReg = writeReg;
		execPayload.regWrite = ctlRegWrite;
		execPayload.aluOp = ctlAluOp;
		execPayload.invA = ctlInvA;
		execPayload.invB = ctlInvB;
		execPayload.Cin = ctlCin;
		execPayload.halt = ctlHalt;
		execPayload.illegal = ctlIllegal;
	end

	assign outValid = inValid;
	// a bubble must not stop fetch
	assign halt = inValid && ctlHalt;

	// halting instruction reaches execute without a write
	noWriteOnHalt: assert property (@(posedge clk) disable iff (!rstN)
		outValid |-> !(execPayload.regWrite && execPayload.halt));

endmodule

//--- verilog/executeUnit.sv
`timescale 1ns/100ps
module executeUnit (
	// inputs
	clk, rstN, inValid, execPayload,
	// outputs
	wrEn, wrReg, wrData, wbValid, wbReg, wbData, dump, err);

	input logic clk, rstN;
	input logic inValid;
	input cpuPkg::execPayloadT execPayload;

	// register file write, same cycle
	output logic wrEn;
	output logic [cpuPkg::regSelWidth-1:0] wrReg;
	output logic [cpuPkg::dataWidth-1:0] wrData;
	// write-back report, one cycle later
	output logic wbValid;
	output logic [cpuPkg::regSelWidth-1:0] wbReg;
	output logic [cpuPkg::dataWidth-1:0] wbData;
	// sticky until reset
	output logic dump, err;

	logic [cpuPkg::dataWidth-1:0] aIn, bIn, aluOut;
	logic [cpuPkg::dataWidth-1:0] carryIn;

	// operand inversion for sub and andn
	assign aIn = execPayload.invA ? ~execPayload.opA : execPayload.opA;
	assign bIn = execPayload.invB ? ~execPayload.opB : execPayload.opB;
	assign carryIn = {{(cpuPkg::dataWidth-1){1'b0}}, execPayload.Cin};

	always_comb begin
		case (execPayload.aluOp)
			cpuPkg::aluAdd: aluOut = aIn + bIn + carryIn;
			cpuPkg::aluXor: aluOut = aIn ^ bIn;
			// B already inverted
			cpuPkg::aluAndn: aluOut = aIn & bIn;
			// slbi, old Rs moves up a byte
			default: aluOut = (aIn << 8) | bIn;
		endcase
	end

	// combinational so decode can bypass it
	assign wrEn = inValid && execPayload.regWrite;
	assign wrReg = execPayload.writeReg;
	assign wrData = aluOut;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbValid <= 1'b0;
			dump <= 1'b0;
			err <= 1'b0;
		end else begin
			wbValid <= wrEn;
			// illegal reports err, plain halt reports dump
			if (inValid && execPayload.halt) begin
				if (execPayload.illegal) begin
					err <= 1'b1;
				end else begin
					dump <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= wrReg;
		wbData <= wrData;
	end

	// fetch has stopped and the younger one was flushed
	quietAfterStop: assert property (@(posedge clk) disable iff (!rstN)
		(dump || err) |-> !wbValid);

endmodule

//--- verilog/cpuTop.sv
`timescale 1ns/100ps
module cpuTop #(parameter int imemAddrWidth = 6) (
	// inputs
	clk, rstN, imemWrEn, imemWrAddr, imemWrData, run,
	// outputs
	wbValid, wbReg, wbData, dump, err);

	input logic clk, rstN;
	input logic imemWrEn;
	input logic [imemAddrWidth-1:0] imemWrAddr;
	input logic [cpuPkg::dataWidth-1:0] imemWrData;
	input logic run;

	output logic wbValid;
	output logic [cpuPkg::regSelWidth-1:0] wbReg;
	output logic [cpuPkg::dataWidth-1:0] wbData;
	output logic dump, err;

	// fetch side
	logic fetchValid, decInValid;
	cpuPkg::fetchPayloadT fetchPayload, decPayload;
	// decode side
	logic halt, decodeValid, exInValid;
	cpuPkg::execPayloadT execPayload, exPayload;
	// write back into the register file
	logic wrEn;
	logic [cpuPkg::regSelWidth-1:0] wrReg;
	logic [cpuPkg::dataWidth-1:0] wrData;

	fetchUnit #(.imemAddrWidth(imemAddrWidth)) i_fetchUnit (
		.clk(clk), .rstN(rstN), .imemWrEn(imemWrEn), .imemWrAddr(imemWrAddr),
		.imemWrData(imemWrData), .run(run), .halt(halt),
		.fetchValid(fetchValid), .fetchPayload(fetchPayload));

	// halt in decode flushes the younger slot
	stageReg #(.payloadT(cpuPkg::fetchPayloadT)) i_fetchReg (
		.clk(clk), .rstN(rstN), .flush(halt), .inValid(fetchValid),
		.inPayload(fetchPayload), .outValid(decInValid), .outPayload(decPayload));

	decodeInstruction i_decode (
		.clk(clk), .rstN(rstN), .inValid(decInValid), .inPayload(decPayload),
		.wrEn(wrEn), .wrReg(wrReg), .wrData(wrData),
		.halt(halt), .outValid(decodeValid), .execPayload(execPayload));

	stageReg #(.payloadT(cpuPkg::execPayloadT)) i_execReg (
		.clk(clk), .rstN(rstN), .flush(1'b0), .inValid(decodeValid),
		.inPayload(execPayload), .outValid(exInValid), .outPayload(exPayload));

	executeUnit i_execute (
		.clk(clk), .rstN(rstN), .inValid(exInValid), .execPayload(exPayload),
		.wrEn(wrEn), .wrReg(wrReg), .wrData(wrData),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .dump(dump), .err(err));

endmodule

//--- verification/cpuTb.sv
`timescale 1ns/100ps
module cpuTb;

	localparam int imemAddrWidth = 6;
	localparam logic [4:0] opIllegal = 5'b00111;

	logic clk, rstN;
	logic imemWrEn;
	logic [imemAddrWidth-1:0] imemWrAddr;
	logic [cpuPkg::dataWidth-1:0] imemWrData;
	logic run;
	logic wbValid;
	logic [cpuPkg::regSelWidth-1:0] wbReg;
	logic [cpuPkg::dataWidth-1:0] wbData;
	logic dump, err;

	integer seed;
	int errorCount, checkCount, testCount, badTests;
	// watchdog budget grows as tests load programs
	int cycleCount, cycleBudget;
	// program under test and the reference results
	logic [15:0] prog[$];
	logic [15:0] modelRegs[8];
	logic [2:0] expReg[$];
	logic [15:0] expData[$];
	logic expDump, expErr;

	cpuTop #(.imemAddrWidth(imemAddrWidth)) i_cpuTop (
		.clk(clk), .rstN(rstN), .imemWrEn(imemWrEn), .imemWrAddr(imemWrAddr),
		.imemWrData(imemWrData), .run(run),
		.wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .dump(dump), .err(err));

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// instruction encoders
	function automatic logic [15:0] rInstr(input logic [1:0] fn, input logic [2:0] rs, rt, rd);
		return {cpuPkg::opAlu, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] iInstr(input logic [4:0] op, input logic [2:0] rs, rd,
		input logic [4:0] imm);
		return {op, rs, rd, imm};
	endfunction

	function automatic logic [15:0] byteInstr(input logic [4:0] op, input logic [2:0] rs,
		input logic [7:0] imm);
		return {op, rs, imm};
	endfunction

	task automatic checkValue(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("error: %s is %0h, expected %0h", name, actual, expected);
		end
	endtask

	task automatic pulseReset;
		@(negedge clk);
		rstN = 1'b0;
		run = 1'b0;
		imemWrEn = 1'b0;
		repeat (10) @(negedge clk);
		rstN = 1'b1;
	endtask

	task automatic beginTest(output int errorsBefore);
		errorsBefore = errorCount;
		cycleBudget += 100;
		prog.delete();
		pulseReset();
	endtask

	task automatic loadProgram;
		cycleBudget += 20 * prog.size();
		for (int i = 0; i < prog.size(); i++) begin
			@(negedge clk);
			imemWrEn = 1'b1;
			imemWrAddr = imemAddrWidth'(i);
			imemWrData = prog[i];
		end
		@(negedge clk);
		imemWrEn = 1'b0;
	endtask

	// ISA reference, walks the program in order until halt or an illegal opcode
	task automatic runModel;
		logic [15:0] instr, rs, rt, result;
		logic [2:0] dest;
		logic writes, stop;
		for (int r = 0; r < 8; r++) begin
			modelRegs[r] = '0;
		end
		expReg.delete();
		expData.delete();
		expDump = 1'b0;
		expErr = 1'b0;
		stop = 1'b0;
		for (int i = 0; i < prog.size() && !stop; i++) begin
			instr = prog[i];
			rs = modelRegs[instr[10:8]];
			rt = modelRegs[instr[7:5]];
			// I-format writes the Rt field by default
			dest = instr[7:5];
			writes = 1'b1;
			result = '0;
			case (instr[15:11])
				cpuPkg::opAlu: begin
					dest = instr[4:2];
					case (instr[1:0])
						cpuPkg::fnAdd: result = rs + rt;
						cpuPkg::fnSub: result = rt - rs;
						cpuPkg::fnXor: result = rs ^ rt;
						default: result = rs & ~rt;
					endcase
				end
				cpuPkg::opAddi: result = rs + {{11{instr[4]}}, instr[4:0]};
				// immediate minus Rs
				cpuPkg::opSubi: result = {{11{instr[4]}}, instr[4:0]} - rs;
				cpuPkg::opXori: result = rs ^ {11'b0, instr[4:0]};
				cpuPkg::opAndni: result = rs & ~{11'b0, instr[4:0]};
				cpuPkg::opLbi: begin
					dest = instr[10:8];
					result = {{8{instr[7]}}, instr[7:0]};
				end
				cpuPkg::opSlbi: begin
					dest = instr[10:8];
					result = {rs[7:0], instr[7:0]};
				end
				cpuPkg::opNop: writes = 1'b0;
				cpuPkg::opHalt: begin
					writes = 1'b0;
					stop = 1'b1;
					expDump = 1'b1;
				end
				default: begin
					writes = 1'b0;
					stop = 1'b1;
					expErr = 1'b1;
				end
			endcase
			if (writes) begin
				modelRegs[dest] = result;
				expReg.push_back(dest);
				expData.push_back(result);
			end
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("test %s: ok", name);
		end else begin
			badTests++;
			$display("test %s: %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	// raise run, compare every write-back, then watch the stopped machine
	task automatic executeProgram(input string name, input int errorsBefore);
		int idx;
		int waitCycles;
		int stopLimit;
		runModel();
		loadProgram();
		idx = 0;
		waitCycles = 0;
		stopLimit = 20 * prog.size() + 20;
		@(negedge clk);
		run = 1'b1;
		while (!(dump || err) && waitCycles < stopLimit) begin
			@(negedge clk);
			waitCycles++;
			if (wbValid) begin
				if (idx < expReg.size()) begin
					checkValue("wbReg", wbReg, expReg[idx]);
					checkValue("wbData", wbData, expData[idx]);
				end else begin
					errorCount++;
					$display("%s: write-back to r%0d after the last expected one", name, wbReg);
				end
				idx++;
			end
		end
		if (!(dump || err)) begin
			errorCount++;
			$display("%s: machine never raised dump or err", name);
		end
		if (idx != expReg.size()) begin
			errorCount++;
			$display("%s: saw %0d write-backs instead of %0d", name, idx, expReg.size());
		end
		// flags sticky, no more write-backs
		repeat (10) begin
			@(negedge clk);
			checkValue("wbValid", wbValid, 1'b0);
			checkValue("dump", dump, expDump);
			checkValue("err", err, expErr);
		end
		run = 1'b0;
		reportTest(name, errorsBefore);
	endtask

	// lbi then slbi puts a random word in each register
	task automatic fillRegs;
		logic [31:0] v;
		for (int r = 0; r < 8; r++) begin
			v = $random(seed);
			prog.push_back(byteInstr(cpuPkg::opLbi, 3'(r), v[15:8]));
			prog.push_back(byteInstr(cpuPkg::opSlbi, 3'(r), v[7:0]));
		end
	endtask

	task automatic testResetIdle;
		int errorsBefore;
		beginTest(errorsBefore);
		prog.push_back(byteInstr(cpuPkg::opLbi, 3'd1, 8'h5a));
		prog.push_back({cpuPkg::opHalt, 11'b0});
		loadProgram();
		// run stays low, nothing may move
		repeat (20) begin
			@(negedge clk);
			checkValue("wbValid", wbValid, 1'b0);
			checkValue("dump", dump, 1'b0);
			checkValue("err", err, 1'b0);
		end
		reportTest("resetIdle", errorsBefore);
	endtask

	task automatic testRegisterOps;
		int errorsBefore;
		logic [31:0] v;
		beginTest(errorsBefore);
		fillRegs();
		// every function code three times
		for (int i = 0; i < 12; i++) begin
			v = $random(seed);
			prog.push_back(rInstr(i[1:0], v[4:2], v[7:5], v[10:8]));
		end
		prog.push_back({cpuPkg::opHalt, 11'b0});
		executeProgram("registerOps", errorsBefore);
	endtask

	task automatic testImmediateOps;
		int errorsBefore;
		logic [31:0] v;
		logic [4:0] imms [5];
		logic [4:0] ops [4];
		beginTest(errorsBefore);
		// negative, most negative, largest positive, zero, random
		imms[0] = 5'h1f;
		imms[1] = 5'h10;
		imms[2] = 5'h0f;
		imms[3] = 5'h00;
		imms[4] = 5'($random(seed));
		ops[0] = cpuPkg::opAddi;
		ops[1] = cpuPkg::opSubi;
		ops[2] = cpuPkg::opXori;
		ops[3] = cpuPkg::opAndni;
		fillRegs();
		for (int k = 0; k < 5; k++) begin
			for (int j = 0; j < 4; j++) begin
				v = $random(seed);
				prog.push_back(iInstr(ops[j], v[2:0], v[5:3], imms[k]));
			end
		end
		prog.push_back({cpuPkg::opHalt, 11'b0});
		executeProgram("immediateOps", errorsBefore);
	endtask

	task automatic testBypassChain;
		int errorsBefore;
		logic [31:0] v;
		logic [2:0] prev;
		logic [4:0] ops [4];
		beginTest(errorsBefore);
		ops[0] = cpuPkg::opAddi;
		ops[1] = cpuPkg::opSubi;
		ops[2] = cpuPkg::opXori;
		ops[3] = cpuPkg::opAndni;
		fillRegs();
		prev = 3'd7;
		// each one reads the result just written
		for (int i = 0; i < 12; i++) begin
			v = $random(seed);
			if (i % 4 == 0) begin
				prog.push_back(rInstr(v[12:11], prev, v[5:3], v[2:0]));
			end else if (i % 4 == 2) begin
				// through the second read port
				prog.push_back(rInstr(v[12:11], v[5:3], prev, v[2:0]));
			end else begin
				prog.push_back(iInstr(ops[v[13:12]], prev, v[2:0], v[10:6]));
			end
			prev = v[2:0];
		end
		prog.push_back(byteInstr(cpuPkg::opSlbi, prev, 8'hc3));
		prog.push_back(iInstr(cpuPkg::opAddi, prev, 3'd0, 5'h01));
		prog.push_back({cpuPkg::opHalt, 11'b0});
		executeProgram("bypassChain", errorsBefore);
	endtask

	task automatic testHaltStops;
		int errorsBefore;
		beginTest(errorsBefore);
		prog.push_back(byteInstr(cpuPkg::opLbi, 3'd1, 8'h81));
		prog.push_back(byteInstr(cpuPkg::opLbi, 3'd2, 8'h17));
		prog.push_back(rInstr(cpuPkg::fnAdd, 3'd1, 3'd2, 3'd3));
		prog.push_back({cpuPkg::opNop, 11'b0});
		prog.push_back({cpuPkg::opHalt, 11'b0});
		// none of these may write back
		prog.push_back(byteInstr(cpuPkg::opLbi, 3'd4, 8'h44));
		prog.push_back(iInstr(cpuPkg::opAddi, 3'd1, 3'd5, 5'h03));
		prog.push_back(rInstr(cpuPkg::fnXor, 3'd1, 3'd2, 3'd6));
		prog.push_back(byteInstr(cpuPkg::opLbi, 3'd7, 8'h77));
		executeProgram("haltStops", errorsBefore);
	endtask

	task automatic testIllegalOpcode;
		int errorsBefore;
		beginTest(errorsBefore);
		prog.push_back(byteInstr(cpuPkg::opLbi, 3'd1, 8'h3c));
		prog.push_back(iInstr(cpuPkg::opSubi, 3'd1, 3'd2, 5'h1c));
		prog.push_back({opIllegal, 11'h2a5});
		prog.push_back(byteInstr(cpuPkg::opLbi, 3'd3, 8'h33));
		prog.push_back(rInstr(cpuPkg::fnSub, 3'd1, 3'd2, 3'd4));
		prog.push_back({cpuPkg::opHalt, 11'b0});
		executeProgram("illegalOpcode", errorsBefore);
	endtask

	// ends the run when the tests overrun their cycle allowance
	initial begin
		while (cycleCount <= cycleBudget) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("timeout: tests ran past %0d cycles", cycleBudget);
		$display("Regression failed");
		$finish;
	end

	initial begin
		rstN = 1'b0;
		run = 1'b0;
		imemWrEn = 1'b0;
		imemWrAddr = '0;
		imemWrData = '0;
		seed = 32'h816f;
		testResetIdle();
		testRegisterOps();
		testImmediateOps();
		testBypassChain();
		testHaltStops();
		testIllegalOpcode();
		$display("tests %0d, with errors %0d, checks %0d, errors %0d",
			testCount, badTests, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- build.f
verilog/cpuPkg.sv
verilog/fetchUnit.sv
verilog/stageReg.sv
verilog/controlUnit.sv
verilog/regFile.sv
verilog/decodeInstruction.sv
verilog/executeUnit.sv
verilog/cpuTop.sv
verification/cpuTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the pipeline testbench with Verilator, result taken from sim.log

cd "$(dirname "$0")" || exit 1

rm -f sim.log
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module cpuTb -f build.f \
	&& ./obj_dir/VcpuTb > sim.log 2>&1 \
	|| echo "run.sh: build or simulation stopped early"

grep -q "^Regression passed$" sim.log \
	&& echo "run.sh: pass" \
	|| { echo "run.sh: fail, see sim.log"; exit 1; }
